// File: hw/cnode_fifo.sv
// register-file FIFO of check-node messages and address tags, registered read data
`include "vnode_defs.svh"

module cnode_fifo (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                write,
  input  vnode_pkg::addr_t    waddr,
  input  vnode_pkg::znode_t   wnode,
  input  logic                read,
  output logic                rval,
  output vnode_pkg::addr_t    raddr,
  output vnode_pkg::znode_t   rnode,
  output logic                empty,
  output logic                full
);

  localparam int DEPTH = 1 << `VN_FIFO_DEPTH_W;

  // storage
  vnode_pkg::addr_t  mem_addr [DEPTH];
  vnode_pkg::znode_t mem_node [DEPTH];

  logic [`VN_FIFO_DEPTH_W-1:0] wptr;
  logic [`VN_FIFO_DEPTH_W-1:0] rptr;
  // fill level, one bit wider than the pointers
  logic [`VN_FIFO_DEPTH_W:0]   used;
  logic [`VN_FIFO_DEPTH_W:0]   used_nxt;

  //--------------------
  // fill level
  //--------------------

  always_comb begin
    case ({write, read})
      2'b10:   used_nxt = used + 1'b1;
      2'b01:   used_nxt = used - 1'b1;
      default: used_nxt = used;
    endcase
  end

  // flags are registered from the next fill level
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wptr  <= '0;
      rptr  <= '0;
      used  <= '0;
      empty <= 1'b1;
      full  <= 1'b0;
      rval  <= 1'b0;
    end else begin
      if (write) begin
        wptr <= wptr + 1'b1;
      end
      if (read) begin
        rptr <= rptr + 1'b1;
      end
      used  <= used_nxt;
      empty <= (used_nxt == '0);
      // depth is a power of two, so the top bit marks full
      full  <= used_nxt[`VN_FIFO_DEPTH_W];
      rval  <= read;
    end
  end

  //--------------------
  // data path
  //--------------------

  always_ff @(posedge iclk) begin
    if (write) begin
      mem_addr[wptr] <= waddr;
      mem_node[wptr] <= wnode;
    end
    if (read) begin
      raddr <= mem_addr[rptr];
      rnode <= mem_node[rptr];
    end
  end

  //--------------------
  // checks
  //--------------------

  a_no_overflow : assert property (
    @(posedge iclk) disable iff (ireset)
    write |-> !full
  );

  a_no_underflow : assert property (
    @(posedge iclk) disable iff (ireset)
    read |-> !empty
  );

endmodule

// File: hw/vnode_acc.sv
// per-lane column accumulator, llr plus all check-node messages of a column, with message count
`include "vnode_defs.svh"

module vnode_acc (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                ival,
  input  logic                isop,
  input  logic                ieop,
  input  vnode_pkg::zllr_t    illr,
  input  vnode_pkg::znode_t   icnode,
  // finished column, held until the next ieop
  output logic                sum_val,
  output vnode_pkg::zsum_t    sum,
  output vnode_pkg::num_t     num_m1
);

  // sums including the current message
  vnode_pkg::zsum_t acc_nxt;

  // message counter shared by all lanes
  vnode_pkg::num_t  cnt;
  vnode_pkg::num_t  cnt_nxt;

  // a column has started and its ieop is still to come
  logic             col_open;

  //--------------------
  // lane sums
  //--------------------

  genvar g;

  generate
    for (g = 0; g < `VN_ZC; g++) begin : lane
      vnode_pkg::sum_t acc;
      vnode_pkg::sum_t base;

      // isop restarts from the sign-extended llr
      assign base = isop ? vnode_pkg::sum_t'($signed(illr[g])) : acc;

      assign acc_nxt[g] = base + vnode_pkg::sum_t'($signed(icnode[g]));

      always_ff @(posedge iclk) begin
        if (ival) begin
          acc <= acc_nxt[g];
        end
      end
    end
  endgenerate

  //--------------------
  // count and column state
  //--------------------

  assign cnt_nxt = isop ? '0 : cnt + 1'b1;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cnt      <= '0;
      col_open <= 1'b0;
    end else if (ival) begin
      cnt      <= cnt_nxt;
      col_open <= ~ieop;
    end
  end

  //--------------------
  // finished column
  //--------------------

  // single cycle strobe one edge after ieop
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      sum_val <= 1'b0;
    end else begin
      sum_val <= ival & ieop;
    end
  end

  // output copy frees the running sums for the next column
  always_ff @(posedge iclk) begin
    if (ival && ieop) begin
      sum    <= acc_nxt;
      num_m1 <= cnt_nxt;
    end
  end

  //--------------------
  // checks
  //--------------------

  // every message opens a column or continues one
  a_open_col : assert property (
    @(posedge iclk) disable iff (ireset)
    ival |-> (isop || col_open)
  );

endmodule

// File: hw/vnode_ctrl.sv
// restore controller, issues one fifo read per stored message of each finished column
module vnode_ctrl (
  input  logic              iclk,
  input  logic              ireset,
  // column finished, with its message count
  input  logic              sum_val,
  input  vnode_pkg::num_t   num_m1,
  // fifo read strobe
  output logic              read
);

  vnode_pkg::ctrl_state_e state;
  // reads still to go after the current one
  vnode_pkg::num_t        cnt;

  //--------------------
  // read fsm
  //--------------------

  // read is high for num_m1+1 cycles, on the edges E+1 .. E+n
  // a new column may start on the last read cycle, giving gapless reads
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= vnode_pkg::CTRL_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        vnode_pkg::CTRL_IDLE: begin
          if (sum_val) begin
            state <= vnode_pkg::CTRL_READ;
            cnt   <= num_m1;
          end
        end
        vnode_pkg::CTRL_READ: begin
          if (cnt != '0) begin
            cnt <= cnt - 1'b1;
          end else if (sum_val) begin
            // back to back column, reload and keep reading
            cnt <= num_m1;
          end else begin
            state <= vnode_pkg::CTRL_IDLE;
          end
        end
        default: begin
          state <= vnode_pkg::CTRL_IDLE;
        end
      endcase
    end
  end

  // state is a register, so read follows the edge after sum_val
  assign read = (state == vnode_pkg::CTRL_READ);

  //--------------------
  // checks
  //--------------------

  // input rule: a column's ieop comes no earlier than the previous column's degree in cycles
  a_col_spacing : assert property (
    @(posedge iclk) disable iff (ireset)
    sum_val |-> !((state == vnode_pkg::CTRL_READ) && (cnt != '0))
  );

endmodule

// File: hw/vnode_pkg.sv
// shared lane types and controller state of the variable-node step, referenced by scoped names
`include "vnode_defs.svh"

package vnode_pkg;

  //--------------------
  // scalar types
  //--------------------

  // channel llr
  typedef logic signed [`VN_LLR_W-1:0]  llr_t;
  // single lane message
  typedef logic signed [`VN_NODE_W-1:0] node_t;
  // column sum of one lane
  typedef logic signed [`VN_SUM_W-1:0]  sum_t;
  // message address tag
  typedef logic [`VN_ADDR_W-1:0]        addr_t;
  // messages per column minus one
  typedef logic [`VN_NUM_W-1:0]         num_t;

  //--------------------
  // lane vectors
  //--------------------

  typedef llr_t  [`VN_ZC-1:0] zllr_t;
  typedef node_t [`VN_ZC-1:0] znode_t;
  typedef sum_t  [`VN_ZC-1:0] zsum_t;
  // one bit per lane, used for hard decisions
  typedef logic  [`VN_ZC-1:0] zdat_t;

  //--------------------
  // restore controller
  //--------------------

  typedef enum logic {
    CTRL_IDLE,
    CTRL_READ
  } ctrl_state_e;

endpackage

// File: hw/vnode_restore.sv
// variable-node restore, column sum minus own message with clamping, plus hard decision per lane
`include "vnode_defs.svh"

module vnode_restore (
  input  logic                iclk,
  input  logic                ireset,
  // column sums from the accumulator
  input  logic                sum_val,
  input  vnode_pkg::zsum_t    sum,
  // stored messages read back from the fifo
  input  logic                rval,
  input  vnode_pkg::addr_t    raddr,
  input  vnode_pkg::znode_t   rnode,
  // outgoing variable-node messages
  output logic                ovnode_val,
  output vnode_pkg::addr_t    ovnode_addr,
  output vnode_pkg::znode_t   ovnode,
  output vnode_pkg::zdat_t    ovnode_hd
);

  // symmetric clamp limits, +/-31 for 6 bit messages
  localparam vnode_pkg::sum_t NODE_MAX = vnode_pkg::sum_t'((1 << (`VN_NODE_W - 1)) - 1);
  localparam vnode_pkg::sum_t NODE_MIN = -NODE_MAX;

  // stage one of the sum delay line
  logic              sum_val_d;
  vnode_pkg::zsum_t  sum_d;
  // stage two, held over the whole read back of a column
  vnode_pkg::zsum_t  sum_hold;

  vnode_pkg::znode_t sat;
  vnode_pkg::zdat_t  hd;

  //--------------------
  // sum alignment
  //--------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      sum_val_d <= 1'b0;
    end else begin
      sum_val_d <= sum_val;
    end
  end

  // hold loads at E+2, together with the column's first fifo entry
  always_ff @(posedge iclk) begin
    if (sum_val) begin
      sum_d <= sum;
    end
    if (sum_val_d) begin
      sum_hold <= sum_d;
    end
  end

  //--------------------
  // per lane extrinsic value
  //--------------------

  genvar g;

  generate
    for (g = 0; g < `VN_ZC; g++) begin : lane
      vnode_pkg::sum_t diff;

      // remove the message that came from this check node
      assign diff = $signed(sum_hold[g]) - vnode_pkg::sum_t'($signed(rnode[g]));

      assign sat[g] = (diff > NODE_MAX) ? vnode_pkg::node_t'(NODE_MAX) :
                      (diff < NODE_MIN) ? vnode_pkg::node_t'(NODE_MIN) :
                                          vnode_pkg::node_t'(diff);

      // hard decision, 1 means negative sum
      assign hd[g] = sum_hold[g][`VN_SUM_W-1];
    end
  endgenerate

  //--------------------
  // outputs
  //--------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ovnode_val <= 1'b0;
    end else begin
      ovnode_val <= rval;
    end
  end

  always_ff @(posedge iclk) begin
    if (rval) begin
      ovnode_addr <= raddr;
      ovnode      <= sat;
      ovnode_hd   <= hd;
    end
  end

endmodule

// File: hw/vnode_unit.sv
// min-sum variable-node step top level, joins accumulator, message FIFO, read control and restore
module vnode_unit (
  input  logic                iclk,
  input  logic                ireset,
  // input message stream
  input  logic                ival,
  input  logic                isop,
  input  logic                ieop,
  input  vnode_pkg::addr_t    iaddr,
  input  vnode_pkg::zllr_t    illr,
  input  vnode_pkg::znode_t   icnode,
  // outgoing variable-node messages
  output logic                ovnode_val,
  output vnode_pkg::addr_t    ovnode_addr,
  output vnode_pkg::znode_t   ovnode,
  output vnode_pkg::zdat_t    ovnode_hd,
  // messages still held in the fifo
  output logic                obusy
);

  // accumulator results, valid one edge after ieop
  logic                acc_sum_val;
  vnode_pkg::zsum_t    acc_sum;
  vnode_pkg::num_t     acc_num_m1;

  // fifo read side
  logic                ctrl_read;
  logic                fifo_rval;
  vnode_pkg::addr_t    fifo_raddr;
  vnode_pkg::znode_t   fifo_rnode;
  logic                fifo_empty;

  //--------------------
  // column sums
  //--------------------

  vnode_acc acc (
    .iclk    ( iclk        ),
    .ireset  ( ireset      ),
    .ival    ( ival        ),
    .isop    ( isop        ),
    .ieop    ( ieop        ),
    .illr    ( illr        ),
    .icnode  ( icnode      ),
    .sum_val ( acc_sum_val ),
    .sum     ( acc_sum     ),
    .num_m1  ( acc_num_m1  )
  );

  //--------------------
  // message store
  //--------------------

  // every valid message is stored together with its tag
  cnode_fifo fifo (
    .iclk   ( iclk       ),
    .ireset ( ireset     ),
    .write  ( ival       ),
    .waddr  ( iaddr      ),
    .wnode  ( icnode     ),
    .read   ( ctrl_read  ),
    .rval   ( fifo_rval  ),
    .raddr  ( fifo_raddr ),
    .rnode  ( fifo_rnode ),
    .empty  ( fifo_empty ),
    .full   (            )
  );

  // empty flag is already a register inside the fifo
  assign obusy = ~fifo_empty;

  //--------------------
  // read back
  //--------------------

  vnode_ctrl ctrl (
    .iclk    ( iclk        ),
    .ireset  ( ireset      ),
    .sum_val ( acc_sum_val ),
    .num_m1  ( acc_num_m1  ),
    .read    ( ctrl_read   )
  );

  vnode_restore restore (
    .iclk        ( iclk        ),
    .ireset      ( ireset      ),
    .sum_val     ( acc_sum_val ),
    .sum         ( acc_sum     ),
    .rval        ( fifo_rval   ),
    .raddr       ( fifo_raddr  ),
    .rnode       ( fifo_rnode  ),
    .ovnode_val  ( ovnode_val  ),
    .ovnode_addr ( ovnode_addr ),
    .ovnode      ( ovnode      ),
    .ovnode_hd   ( ovnode_hd   )
  );

endmodule

// File: include/vnode_defs.svh
// widths, lane count and FIFO depth of the variable-node step, included wherever a size is needed
`ifndef VNODE_DEFS_SVH
`define VNODE_DEFS_SVH

//--------------------
// lanes
//--------------------

// number of parallel lanes
`define VN_ZC 4

//--------------------
// data widths
//--------------------

// channel llr, signed
`define VN_LLR_W 4
// check/variable node message, signed, clamped to +/-31
`define VN_NODE_W 6
// column sum, holds llr plus VN_MAX_DEG messages
`define VN_SUM_W 10
// address tag carried with each message
`define VN_ADDR_W 8

//--------------------
// column size
//--------------------

// largest number of messages in one column
`define VN_MAX_DEG 8
// width of message count minus one
`define VN_NUM_W 3
// fifo depth exponent, 16 entries = two full columns
`define VN_FIFO_DEPTH_W 4

`endif

// File: run.sh
#!/bin/sh
# builds the vnode_unit testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_vnode_unit -Mdir obj_dir -f vnode_unit.f

./obj_dir/Vtb_vnode_unit > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failure"

// File: tests/tb_vnode_unit.sv
// directed testbench of vnode_unit that drives whole columns and checks every restored message
`include "vnode_defs.svh"

module tb_vnode_unit;
  timeunit 1ns;
  timeprecision 100ps;

  // cycles any single wait may take
  localparam int TIMEOUT = 300;
  // symmetric message limit of 31
  localparam int NODE_LIM = (1 << (`VN_NODE_W - 1)) - 1;

  logic                iclk;
  logic                ireset;
  logic                ival;
  logic                isop;
  logic                ieop;
  vnode_pkg::addr_t    iaddr;
  vnode_pkg::zllr_t    illr;
  vnode_pkg::znode_t   icnode;
  logic                ovnode_val;
  vnode_pkg::addr_t    ovnode_addr;
  vnode_pkg::znode_t   ovnode;
  vnode_pkg::zdat_t    ovnode_hd;
  logic                obusy;

  // posedges seen so far and read only on falling edges
  int                  cyc = 0;
  int                  checks = 0;
  int                  errors = 0;
  int                  timeouts = 0;
  string               test_name = "reset";
  logic [15:0]         lfsr;

  // expected outputs in arrival order
  // a cycle of -1 means untimed
  vnode_pkg::addr_t    exp_addr_q [$];
  vnode_pkg::znode_t   exp_node_q [$];
  vnode_pkg::zdat_t    exp_hd_q [$];
  int                  exp_cyc_q [$];

  // column being built
  vnode_pkg::zllr_t    col_llr;
  vnode_pkg::znode_t   col_msg [`VN_MAX_DEG];
  vnode_pkg::addr_t    col_addr [`VN_MAX_DEG];
  vnode_pkg::addr_t    next_addr = '0;
  // input rule bookkeeping
  int                  prev_deg = 0;
  int                  last_eop_cyc = -100;

  vnode_unit dut (
    .iclk        ( iclk        ),
    .ireset      ( ireset      ),
    .ival        ( ival        ),
    .isop        ( isop        ),
    .ieop        ( ieop        ),
    .iaddr       ( iaddr       ),
    .illr        ( illr        ),
    .icnode      ( icnode      ),
    .ovnode_val  ( ovnode_val  ),
    .ovnode_addr ( ovnode_addr ),
    .ovnode      ( ovnode      ),
    .ovnode_hd   ( ovnode_hd   ),
    .obusy       ( obusy       )
  );

  initial begin
    iclk = 1'b0;
    forever #5 iclk = ~iclk;
  end

  always @(posedge iclk) begin
    cyc <= cyc + 1;
  end

  //--------------------
  // random source
  //--------------------

  // galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic int unsigned take_bits(input int w);
    int unsigned v;
    v = 0;
    for (int i = 0; i < w; i++) begin
      v = (v << 1) | lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic int clamp_node(input int v);
    if (v > NODE_LIM)
      return NODE_LIM;
    if (v < -NODE_LIM)
      return -NODE_LIM;
    return v;
  endfunction

  //--------------------
  // compare tasks
  //--------------------

  task automatic check_node(input string what, input vnode_pkg::node_t exp,
                            input vnode_pkg::node_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_addr(input string what, input vnode_pkg::addr_t exp,
                            input vnode_pkg::addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic check_hd(input string what, input vnode_pkg::zdat_t exp,
                          input vnode_pkg::zdat_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  // output arrival cycle against the E+3+i rule
  task automatic check_cycle(input string what, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  //--------------------
  // output monitor
  //--------------------

  // outputs are registered, so the falling edge sees them settled
  always @(negedge iclk) begin
    int exp_c;
    vnode_pkg::znode_t exp_n;
    if (!ireset && ovnode_val) begin
      if (exp_addr_q.size() == 0) begin
        errors++;
        $display("ERROR: %s: output valid while no message was expected", test_name);
      end else begin
        exp_n = exp_node_q.pop_front();
        exp_c = exp_cyc_q.pop_front();
        check_addr("ovnode_addr", exp_addr_q.pop_front(), ovnode_addr);
        check_hd("ovnode_hd", exp_hd_q.pop_front(), ovnode_hd);
        for (int l = 0; l < `VN_ZC; l++) begin
          check_node($sformatf("ovnode[%0d]", l), exp_n[l], ovnode[l]);
        end
        if (exp_c >= 0) begin
          check_cycle("output cycle", exp_c, cyc);
        end
      end
    end
  end

  //--------------------
  // stimulus helpers
  //--------------------

  // every drive starts and ends on a falling edge
  task automatic drive_idle();
    ival = 1'b0;
    isop = 1'b0;
    ieop = 1'b0;
    @(negedge iclk);
  endtask

  task automatic drive_msg(input bit sop, input bit eop, input vnode_pkg::addr_t a,
                           input vnode_pkg::znode_t m);
    ival   = 1'b1;
    isop   = sop;
    ieop   = eop;
    iaddr  = a;
    illr   = col_llr;
    icnode = m;
    @(negedge iclk);
    ival = 1'b0;
    isop = 1'b0;
    ieop = 1'b0;
  endtask

  task automatic fill_random(input int n);
    for (int l = 0; l < `VN_ZC; l++) begin
      col_llr[l] = vnode_pkg::llr_t'(take_bits(`VN_LLR_W));
      for (int i = 0; i < n; i++) begin
        col_msg[i][l] = vnode_pkg::node_t'(take_bits(`VN_NODE_W));
      end
    end
  endtask

  // sends one column and then queues the model results for it
  task automatic send_column(input int n, input bit gaps, input bit timed);
    int eop_cyc;
    int sum_lane [`VN_ZC];
    vnode_pkg::znode_t vout;
    vnode_pkg::zdat_t hd;
    eop_cyc = 0;
    for (int i = 0; i < n; i++) begin
      if (gaps && take_bits(1) == 1) begin
        repeat (1 + take_bits(2)) drive_idle();
      end
      if (i == n - 1) begin
        // ieop no sooner than the previous degree after the previous ieop
        while (cyc - last_eop_cyc < prev_deg) begin
          drive_idle();
        end
        eop_cyc = cyc;
      end
      col_addr[i] = next_addr;
      next_addr   = next_addr + 1'b1;
      drive_msg(i == 0, i == n - 1, col_addr[i], col_msg[i]);
    end
    prev_deg     = n;
    last_eop_cyc = eop_cyc;
    // column sum is llr plus every message
    for (int l = 0; l < `VN_ZC; l++) begin
      sum_lane[l] = $signed(col_llr[l]);
      for (int i = 0; i < n; i++) begin
        sum_lane[l] = sum_lane[l] + $signed(col_msg[i][l]);
      end
    end
    // each output leaves out its own message
    for (int i = 0; i < n; i++) begin
      for (int l = 0; l < `VN_ZC; l++) begin
        vout[l] = vnode_pkg::node_t'(clamp_node(sum_lane[l] - $signed(col_msg[i][l])));
        hd[l]   = (sum_lane[l] < 0);
      end
      exp_addr_q.push_back(col_addr[i]);
      exp_node_q.push_back(vout);
      exp_hd_q.push_back(hd);
      exp_cyc_q.push_back(timed ? eop_cyc + 4 + i : -1);
    end
  endtask

  // all expected outputs seen and the fifo empty
  task automatic wait_drain();
    int t;
    for (t = 0; t < TIMEOUT; t++) begin
      @(negedge iclk);
      if (exp_addr_q.size() == 0 && !obusy && !ovnode_val)
        break;
    end
    if (t == TIMEOUT) begin
      timeouts++;
      $display("ERROR: %s: outputs did not drain within %0d cycles", test_name, TIMEOUT);
    end
  endtask

  //--------------------
  // tests
  //--------------------

  task automatic reset_outputs_low();
    test_name = "reset";
    check_bit("ovnode_val", 1'b0, ovnode_val);
    check_bit("obusy", 1'b0, obusy);
  endtask

  task automatic single_column();
    test_name = "single_column";
    fill_random(3);
    send_column(3, 1'b0, 1'b1);
    wait_drain();
  endtask

  // full degree with llr and messages at the range ends and lanes of both signs
  task automatic saturation_clamp();
    bit neg;
    test_name = "saturation";
    for (int c = 0; c < 2; c++) begin
      for (int l = 0; l < `VN_ZC; l++) begin
        neg = ((l % 2) == c);
        col_llr[l] = neg ? vnode_pkg::llr_t'(-(1 << (`VN_LLR_W - 1))) :
                           vnode_pkg::llr_t'((1 << (`VN_LLR_W - 1)) - 1);
        for (int i = 0; i < `VN_MAX_DEG; i++) begin
          col_msg[i][l] = neg ? vnode_pkg::node_t'(-(1 << (`VN_NODE_W - 1))) :
                                vnode_pkg::node_t'(NODE_LIM);
        end
      end
      send_column(`VN_MAX_DEG, 1'b0, 1'b1);
    end
    wait_drain();
  endtask

  task automatic back_to_back_stream();
    int n;
    test_name = "back_to_back";
    repeat (20) begin
      n = 1 + take_bits(3);
      fill_random(n);
      send_column(n, 1'b0, 1'b0);
    end
    wait_drain();
  endtask

  task automatic gapped_stream();
    int n;
    test_name = "gaps";
    repeat (10) begin
      n = 1 + take_bits(3);
      fill_random(n);
      send_column(n, 1'b1, 1'b0);
    end
    wait_drain();
  endtask

  task automatic busy_until_drained();
    int t;
    test_name = "busy";
    fill_random(6);
    send_column(6, 1'b0, 1'b0);
    // reads start two edges after E, so the whole column still waits
    check_bit("obusy", 1'b1, obusy);
    for (t = 0; t < TIMEOUT && obusy; t++) begin
      @(negedge iclk);
    end
    if (obusy) begin
      timeouts++;
      $display("ERROR: %s: obusy still high after %0d cycles", test_name, TIMEOUT);
    end
    wait_drain();
  endtask

  //--------------------
  // main sequence
  //--------------------

  initial begin
    ireset = 1'b1;
    ival   = 1'b0;
    isop   = 1'b0;
    ieop   = 1'b0;
    iaddr  = '0;
    illr   = '0;
    icnode = '0;
    lfsr   = 16'd98;
    repeat (8) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;

    reset_outputs_low();
    single_column();
    saturation_clamp();
    back_to_back_stream();
    gapped_stream();
    busy_until_drained();

    $display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: vnode_unit.f
+incdir+include
hw/vnode_pkg.sv
hw/cnode_fifo.sv
hw/vnode_acc.sv
hw/vnode_ctrl.sv
hw/vnode_restore.sv
hw/vnode_unit.sv
tests/tb_vnode_unit.sv
